/* common/board_cfg_pkg.sv */
`default_nettype none

package board_cfg_pkg;

	// spi command codes from the board controller.
	localparam logic [7:0] cmd_buttons = 8'h01;
	localparam logic [7:0] cmd_key     = 8'h05;
	localparam logic [7:0] cmd_status  = 8'h1E;

	localparam int key_width    = 11;
	localparam int status_width = 32;

	// status word bits.
	localparam int st_reset_bit      = 0;
	localparam int st_menu_reset_bit = 9;
	localparam int st_scanline_lo    = 2;

	// field positions in the buttons payload byte.
	localparam int cfg_buttons_lo     = 0;
	localparam int cfg_switches_lo    = 2;
	localparam int cfg_sd_disable_bit = 4;

	// button that forces a core reset.
	localparam int btn_reset_bit = 1;

endpackage

`default_nettype wire

/* common/av_pkg.sv */
`default_nettype none

package av_pkg;

	// vga colour depth per channel.
	localparam int color_width = 6;

	// scanline modes from status bits 3:2.
	localparam logic [1:0] scan_mode_none = 2'd0;
	localparam logic [1:0] scan_mode_25   = 2'd1;
	localparam logic [1:0] scan_mode_50   = 2'd2;
	localparam logic [1:0] scan_mode_75   = 2'd3;

	// colour level of a lit pixel on a darkened line.
	localparam logic [5:0] scan_level_none = 6'd63;
	localparam logic [5:0] scan_level_25   = 6'd47;
	localparam logic [5:0] scan_level_50   = 6'd31;
	localparam logic [5:0] scan_level_75   = 6'd15;

	// audio sample width shared by both channels.
	localparam int sample_width = 16;

endpackage

`default_nettype wire

/* user_io/spi_user_io.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_user_io (
	input  wire                                      clk_sys,
	input  wire                                      rst,
	input  wire                                      SPI_SCK,
	input  wire                                      SPI_DI,
	input  wire                                      SPI_SS_IO,
	input  wire                                      key_ack,
	output logic [board_cfg_pkg::status_width-1:0]   status,
	output logic [1:0]                               buttons,
	output logic [1:0]                               switches,
	output logic                                     scandoubler_disable,
	output logic                                     core_reset,
	output logic                                     key_req,
	output logic [board_cfg_pkg::key_width-1:0]      key_data
);

	logic [1:0]  sck_sync;
	logic [1:0]  di_sync;
	logic [1:0]  ss_sync;
	logic        sck_d;
	logic        sck_rise;
	logic [2:0]  bit_cnt;
	logic [6:0]  shift;
	logic [7:0]  rx_byte;
	logic        byte_done;
	logic [2:0]  byte_idx;
	logic [7:0]  cmd;
	logic [23:0] status_lo;
	logic [2:0]  key_hi;
	logic        key_new;
	logic [board_cfg_pkg::key_width-1:0] new_key;
	logic        ack_wait;
	logic        hs_free;
	logic        pend_valid;
	logic        pend_load;
	logic [board_cfg_pkg::key_width-1:0] pend_data;

	// two-flop synchronizers with ss idling high.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sck_sync <= 2'b00;
			di_sync  <= 2'b00;
			ss_sync  <= 2'b11;
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], SPI_SCK};
			di_sync  <= {di_sync[0], SPI_DI};
			ss_sync  <= {ss_sync[0], SPI_SS_IO};
			sck_d    <= sck_sync[1];
		end
	end

	assign sck_rise  = sck_sync[1] & ~sck_d;
	assign rx_byte   = {shift, di_sync[1]};
	assign byte_done = sck_rise && !ss_sync[1] && (bit_cnt == 3'd7);

	// msb first.
	always_ff @(posedge clk_sys) begin
		if (sck_rise)
			shift <= rx_byte[6:0];
	end

	// byte index saturates, so trailing bytes are ignored.
	always_ff @(posedge clk_sys) begin
		if (rst || ss_sync[1]) begin
			bit_cnt  <= 3'd0;
			byte_idx <= 3'd0;
			cmd      <= 8'h00;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				if (byte_idx == 3'd0)
					cmd <= rx_byte;
				if (byte_idx != 3'd7)
					byte_idx <= byte_idx + 3'd1;
			end
		end
	end

	// status arrives lsb first.
	always_ff @(posedge clk_sys) begin
		if (byte_done && cmd == board_cfg_pkg::cmd_status && byte_idx != 3'd0)
			status_lo <= {rx_byte, status_lo[23:8]};
		if (byte_done && cmd == board_cfg_pkg::cmd_key && byte_idx == 3'd1)
			key_hi <= rx_byte[2:0];
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status              <= '0;
			buttons             <= 2'b00;
			switches            <= 2'b00;
			scandoubler_disable <= 1'b0;
		end else if (byte_done) begin
			if (cmd == board_cfg_pkg::cmd_status && byte_idx == 3'd4)
				status <= {rx_byte, status_lo};
			if (cmd == board_cfg_pkg::cmd_buttons && byte_idx == 3'd1) begin
				buttons             <= rx_byte[board_cfg_pkg::cfg_buttons_lo +: 2];
				switches            <= rx_byte[board_cfg_pkg::cfg_switches_lo +: 2];
				scandoubler_disable <= rx_byte[board_cfg_pkg::cfg_sd_disable_bit];
			end
		end
	end

	assign key_new = byte_done && cmd == board_cfg_pkg::cmd_key && byte_idx == 3'd2;
	assign new_key = {key_hi, rx_byte};

	// free when idle, or when the ack just went low.
	assign hs_free   = (!key_req && !ack_wait) || (ack_wait && !key_ack);
	assign pend_load = key_new && (hs_free ? pend_valid : !pend_valid);

	always_ff @(posedge clk_sys) begin
		if (pend_load)
			pend_data <= new_key;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			key_req    <= 1'b0;
			key_data   <= '0;
			ack_wait   <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			if (key_req && key_ack) begin
				key_req  <= 1'b0;
				ack_wait <= 1'b1;
			end else if (hs_free) begin
				ack_wait <= 1'b0;
				if (pend_valid) begin
					key_req    <= 1'b1;
					key_data   <= pend_data;
					pend_valid <= key_new;
				end else if (key_new) begin
					key_req  <= 1'b1;
					key_data <= new_key;
				end
			end
			// a key while busy takes the slot if it is empty, else it is lost.
			if (!hs_free && key_new && !pend_valid)
				pend_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			core_reset <= 1'b1;
		else
			core_reset <= status[board_cfg_pkg::st_reset_bit] |
			              status[board_cfg_pkg::st_menu_reset_bit] |
			              buttons[board_cfg_pkg::btn_reset_bit];
	end

	a_req_hold: assert property (@(posedge clk_sys) disable iff (rst)
		key_req && !key_ack |=> key_req)
		else $error("key_req dropped before key_ack");

	a_data_stable: assert property (@(posedge clk_sys) disable iff (rst)
		key_req && !key_ack |=> $stable(key_data))
		else $error("key_data changed during an open request");

endmodule

`default_nettype wire

/* video/video_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module video_mixer (
	input  wire                                clk_sys,
	input  wire                                rst,
	input  wire                                video_r,
	input  wire                                video_g,
	input  wire                                video_b,
	input  wire                                video_hs,
	input  wire                                video_vs,
	input  wire  [1:0]                         scanline_mode,
	input  wire                                scandoubler_disable,
	output logic [av_pkg::color_width-1:0]     VGA_R,
	output logic [av_pkg::color_width-1:0]     VGA_G,
	output logic [av_pkg::color_width-1:0]     VGA_B,
	output logic                               VGA_HS,
	output logic                               VGA_VS
);

	logic                           hs_d;
	logic                           line_odd;
	logic [av_pkg::color_width-1:0] scan_level;
	logic [av_pkg::color_width-1:0] lit_level;

	always_comb begin
		case (scanline_mode)
			av_pkg::scan_mode_25: scan_level = av_pkg::scan_level_25;
			av_pkg::scan_mode_50: scan_level = av_pkg::scan_level_50;
			av_pkg::scan_mode_75: scan_level = av_pkg::scan_level_75;
			default:              scan_level = av_pkg::scan_level_none;
		endcase
	end

	// darkening only on odd lines with the scandoubler on.
	assign lit_level = (line_odd && !scandoubler_disable) ? scan_level
	                                                      : av_pkg::scan_level_none;

	// line parity restarts every frame.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_d     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_d <= video_hs;
			if (video_vs)
				line_odd <= 1'b0;
			else if (video_hs && !hs_d)
				line_odd <= ~line_odd;
		end
	end

	// colours and syncs share one register stage.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			VGA_R  <= '0;
			VGA_G  <= '0;
			VGA_B  <= '0;
			VGA_HS <= 1'b0;
			VGA_VS <= 1'b0;
		end else begin
			VGA_R  <= video_r ? lit_level : '0;
			VGA_G  <= video_g ? lit_level : '0;
			VGA_B  <= video_b ? lit_level : '0;
			VGA_HS <= video_hs;
			VGA_VS <= video_vs;
		end
	end

	a_sync_delay: assert property (@(posedge clk_sys) disable iff (rst)
		!$past(rst) |-> (VGA_HS == $past(video_hs)) && (VGA_VS == $past(video_vs)))
		else $error("vga syncs not one cycle behind the core syncs");

endmodule

`default_nettype wire

/* design/sigma_delta_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac (
	input  wire                              clk_sys,
	input  wire                              rst,
	input  wire  [av_pkg::sample_width-1:0]  sample,
	output logic                             dac_out
);

	// one bit wider than the sample so the top bit is the carry.
	logic [av_pkg::sample_width:0] acc;

	always_ff @(posedge clk_sys) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[av_pkg::sample_width-1:0]} + {1'b0, sample};
	end

	// carry density tracks sample / 2^16.
	assign dac_out = acc[av_pkg::sample_width];

endmodule

`default_nettype wire

/* design/oric_board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module oric_board_top (
	input  wire                                     clk_sys,
	input  wire                                     rst,
	input  wire                                     SPI_SCK,
	input  wire                                     SPI_DI,
	input  wire                                     SPI_SS_IO,
	input  wire                                     video_r,
	input  wire                                     video_g,
	input  wire                                     video_b,
	input  wire                                     video_hs,
	input  wire                                     video_vs,
	input  wire  [av_pkg::sample_width-1:0]         audio_l,
	input  wire  [av_pkg::sample_width-1:0]         audio_r,
	input  wire                                     key_ack,
	output wire  [av_pkg::color_width-1:0]          VGA_R,
	output wire  [av_pkg::color_width-1:0]          VGA_G,
	output wire  [av_pkg::color_width-1:0]          VGA_B,
	output wire                                     VGA_HS,
	output wire                                     VGA_VS,
	output wire                                     AUDIO_L,
	output wire                                     AUDIO_R,
	output wire                                     core_reset,
	output wire                                     key_req,
	output wire  [board_cfg_pkg::key_width-1:0]     key_data,
	output wire  [board_cfg_pkg::status_width-1:0]  status
);

	wire scandoubler_disable;

	spi_user_io u_spi_user_io (
		.clk_sys             (clk_sys),
		.rst                 (rst),
		.SPI_SCK             (SPI_SCK),
		.SPI_DI              (SPI_DI),
		.SPI_SS_IO           (SPI_SS_IO),
		.key_ack             (key_ack),
		.status              (status),
		.buttons             (),
		.switches            (),
		.scandoubler_disable (scandoubler_disable),
		.core_reset          (core_reset),
		.key_req             (key_req),
		.key_data            (key_data)
	);

	video_mixer u_video_mixer (
		.clk_sys             (clk_sys),
		.rst                 (rst),
		.video_r             (video_r),
		.video_g             (video_g),
		.video_b             (video_b),
		.video_hs            (video_hs),
		.video_vs            (video_vs),
		.scanline_mode       (status[board_cfg_pkg::st_scanline_lo +: 2]),
		.scandoubler_disable (scandoubler_disable),
		.VGA_R               (VGA_R),
		.VGA_G               (VGA_G),
		.VGA_B               (VGA_B),
		.VGA_HS              (VGA_HS),
		.VGA_VS              (VGA_VS)
	);

	sigma_delta_dac u_dac_l (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (audio_l),
		.dac_out (AUDIO_L)
	);

	sigma_delta_dac u_dac_r (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (audio_r),
		.dac_out (AUDIO_R)
	);

endmodule

`default_nettype wire

/* verification/tb_spi_tasks.svh */
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// one byte in spi mode 0 with msb first.
task automatic shift_out_byte(input logic [7:0] value);
	for (int i = 7; i >= 0; i--) begin
		SPI_SCK <= 1'b0;
		SPI_DI  <= value[i];
		repeat (spi_half) @(posedge clk_sys);
		SPI_SCK <= 1'b1;
		repeat (spi_half) @(posedge clk_sys);
	end
endtask

// payload bytes go out from the low byte up.
task automatic send_command(input logic [7:0] cmd, input logic [31:0] payload,
		input int count);
	@(posedge clk_sys);
	SPI_SS_IO <= 1'b0;
	repeat (spi_half) @(posedge clk_sys);
	shift_out_byte(cmd);
	for (int i = 0; i < count; i++)
		shift_out_byte(payload[8*i +: 8]);
	SPI_SCK <= 1'b0;
	repeat (spi_half) @(posedge clk_sys);
	SPI_SS_IO <= 1'b1;
	repeat (spi_half) @(posedge clk_sys);
endtask

task automatic send_status_word(input logic [31:0] word);
	send_command(board_cfg_pkg::cmd_status, word, 4);
endtask

task automatic send_config_byte(input logic [7:0] cfg);
	send_command(board_cfg_pkg::cmd_buttons, {24'd0, cfg}, 1);
endtask

// high key bits travel in the first byte.
task automatic send_key_event(input logic [board_cfg_pkg::key_width-1:0] key);
	send_command(board_cfg_pkg::cmd_key, {16'd0, key[7:0], 5'd0, key[10:8]}, 2);
endtask

task automatic wait_key_req(input logic level, output bit seen);
	int waited;
	seen = 1'b0;
	waited = 0;
	while (!seen && waited < 64) begin
		@(negedge clk_sys);
		seen = (key_req == level);
		waited++;
	end
	assert (seen) else begin
		fail_count++;
		$display("%0t: key handshake stalled, key_req never went to %0b", $time, level);
	end
endtask

// full four-phase cycle from the core side.
task automatic accept_key(input logic [board_cfg_pkg::key_width-1:0] expected);
	bit seen;
	wait_key_req(1'b1, seen);
	if (seen)
		compare_value("key_data", key_data, expected);
	@(posedge clk_sys);
	key_ack <= 1'b1;
	wait_key_req(1'b0, seen);
	@(posedge clk_sys);
	key_ack <= 1'b0;
endtask

`endif

/* verification/tb_oric_board.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_oric_board;

	localparam int spi_half    = 8;
	localparam int num_rows    = 10;
	localparam int cycle_limit = num_rows * 600 + 3 * 65536 + 2000;

	typedef struct packed {
		logic [31:0] status_word;
		logic [7:0]  cfg_byte;
		logic [2:0]  rgb;
		logic [3:0]  hs_pulses;
		logic [5:0]  exp_r;
		logic [5:0]  exp_g;
		logic [5:0]  exp_b;
		logic        exp_reset;
	} row_t;

	logic        clk_sys;
	logic        rst;
	logic        SPI_SCK;
	logic        SPI_DI;
	logic        SPI_SS_IO;
	logic        video_r;
	logic        video_g;
	logic        video_b;
	logic        video_hs;
	logic        video_vs;
	logic [15:0] audio_l;
	logic [15:0] audio_r;
	logic        key_ack;
	wire  [5:0]  VGA_R;
	wire  [5:0]  VGA_G;
	wire  [5:0]  VGA_B;
	wire         VGA_HS;
	wire         VGA_VS;
	wire         AUDIO_L;
	wire         AUDIO_R;
	wire         core_reset;
	wire         key_req;
	wire  [10:0] key_data;
	wire  [31:0] status;

	row_t rows [num_rows];
	int   mismatch_count = 0;
	int   fail_count = 0;
	int   cycle_count;
	bit   sync_check_on = 1'b0;
	logic hs_seen;
	logic vs_seen;

	oric_board_top u_oric_board_top (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.SPI_SCK    (SPI_SCK),
		.SPI_DI     (SPI_DI),
		.SPI_SS_IO  (SPI_SS_IO),
		.video_r    (video_r),
		.video_g    (video_g),
		.video_b    (video_b),
		.video_hs   (video_hs),
		.video_vs   (video_vs),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.key_ack    (key_ack),
		.VGA_R      (VGA_R),
		.VGA_G      (VGA_G),
		.VGA_B      (VGA_B),
		.VGA_HS     (VGA_HS),
		.VGA_VS     (VGA_VS),
		.AUDIO_L    (AUDIO_L),
		.AUDIO_R    (AUDIO_R),
		.core_reset (core_reset),
		.key_req    (key_req),
		.key_data   (key_data),
		.status     (status)
	);

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	`include "tb_spi_tasks.svh"

	task automatic add_row(input int idx, input logic [31:0] st, input logic [7:0] cfg,
			input logic [2:0] rgb, input logic [3:0] pulses, input logic [5:0] er,
			input logic [5:0] eg, input logic [5:0] eb, input logic erst);
		rows[idx] = {st, cfg, rgb, pulses, er, eg, eb, erst};
	endtask

	// cfg byte has buttons in bits 1:0, switches in 3:2 and scandoubler off in 4.
	task automatic load_table();
		add_row(0, 32'h0000_0000, 8'h00, 3'b101, 4'd1, 6'd63, 6'd0, 6'd63, 1'b0);
		add_row(1, 32'h0000_0004, 8'h00, 3'b111, 4'd1, av_pkg::scan_level_25,
			av_pkg::scan_level_25, av_pkg::scan_level_25, 1'b0);
		add_row(2, 32'h0000_0004, 8'h00, 3'b110, 4'd2, 6'd63, 6'd63, 6'd0, 1'b0);
		add_row(3, 32'hA5C3_0008, 8'h00, 3'b011, 4'd3, 6'd0, av_pkg::scan_level_50,
			av_pkg::scan_level_50, 1'b0);
		add_row(4, 32'h5A00_F00C, 8'h00, 3'b111, 4'd1, av_pkg::scan_level_75,
			av_pkg::scan_level_75, av_pkg::scan_level_75, 1'b0);
		add_row(5, 32'h5A00_F00C, 8'h1C, 3'b111, 4'd1, 6'd63, 6'd63, 6'd63, 1'b0);
		add_row(6, 32'h5A00_F00D, 8'h1C, 3'b100, 4'd1, 6'd63, 6'd0, 6'd0, 1'b1);
		add_row(7, 32'h0000_020C, 8'h00, 3'b010, 4'd1, 6'd0, av_pkg::scan_level_75,
			6'd0, 1'b1);
		add_row(8, 32'h0000_000C, 8'h02, 3'b001, 4'd3, 6'd0, 6'd0,
			av_pkg::scan_level_75, 1'b1);
		add_row(9, 32'h0000_000C, 8'h00, 3'b111, 4'd0, 6'd63, 6'd63, 6'd63, 1'b0);
	endtask

	// vsync restarts the line parity.
	task automatic start_frame(input logic [2:0] rgb);
		@(posedge clk_sys);
		video_r  <= rgb[2];
		video_g  <= rgb[1];
		video_b  <= rgb[0];
		video_vs <= 1'b1;
		repeat (2) @(posedge clk_sys);
		video_vs <= 1'b0;
	endtask

	task automatic pulse_hsync();
		repeat (2) @(posedge clk_sys);
		video_hs <= 1'b1;
		repeat (2) @(posedge clk_sys);
		video_hs <= 1'b0;
	endtask

	task automatic check_density(input string what, input int ones, input int sample);
		int diff;
		diff = ones - sample;
		assert (diff >= -1 && diff <= 1) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s gave %0d ones, expected %0d", $time, what, ones,
				sample);
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// syncs must be the inputs of the previous cycle.
	always @(negedge clk_sys) begin
		if (sync_check_on) begin
			assert (VGA_HS === hs_seen && VGA_VS === vs_seen) else begin
				mismatch_count++;
				$display("Mismatch at %0t: VGA syncs %b%b, expected %b%b", $time, VGA_HS,
					VGA_VS, hs_seen, vs_seen);
			end
		end
		hs_seen = video_hs;
		vs_seen = video_vs;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int extra_req;
		int ones_l;
		int ones_r;
		logic [31:0] cur_status;
		logic [7:0]  cur_cfg;
		logic [10:0] key1;
		logic [10:0] key2;
		logic [10:0] key3;
		logic [15:0] s_l;
		logic [15:0] s_r;

		rst       = 1'b1;
		SPI_SCK   = 1'b0;
		SPI_DI    = 1'b0;
		SPI_SS_IO = 1'b1;
		video_r   = 1'b0;
		video_g   = 1'b0;
		video_b   = 1'b0;
		video_hs  = 1'b0;
		video_vs  = 1'b0;
		audio_l   = 16'd0;
		audio_r   = 16'd0;
		key_ack   = 1'b0;
		void'($urandom(82980));
		load_table();
		cur_status = 32'd0;
		cur_cfg    = 8'd0;

		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("core_reset in reset", core_reset, 1);
		compare_value("key_req in reset", key_req, 0);
		compare_value("status in reset", status, 0);
		compare_value("VGA colours in reset", {VGA_R, VGA_G, VGA_B}, 0);
		compare_value("audio in reset", {AUDIO_L, AUDIO_R}, 0);
		@(posedge clk_sys);
		rst <= 1'b0;
		sync_check_on = 1'b1;
		@(negedge clk_sys);

		for (int i = 0; i < num_rows; i++) begin
			if (rows[i].status_word != cur_status) begin
				send_status_word(rows[i].status_word);
				cur_status = rows[i].status_word;
			end
			if (rows[i].cfg_byte != cur_cfg) begin
				send_config_byte(rows[i].cfg_byte);
				cur_cfg = rows[i].cfg_byte;
			end
			start_frame(rows[i].rgb);
			repeat (rows[i].hs_pulses) pulse_hsync();
			repeat (3) @(posedge clk_sys);
			@(negedge clk_sys);
			compare_value($sformatf("row %0d status", i), status, rows[i].status_word);
			compare_value($sformatf("row %0d core_reset", i), core_reset, rows[i].exp_reset);
			compare_value($sformatf("row %0d VGA_R", i), VGA_R, rows[i].exp_r);
			compare_value($sformatf("row %0d VGA_G", i), VGA_G, rows[i].exp_g);
			compare_value($sformatf("row %0d VGA_B", i), VGA_B, rows[i].exp_b);
		end

		// second key waits in the slot and the third finds it full.
		key1 = 11'($urandom);
		key2 = key1 + 11'd1 + 11'($urandom % 1000);
		key3 = key2 + 11'd1 + 11'($urandom % 500);
		send_key_event(key1);
		@(negedge clk_sys);
		compare_value("key_req after first key", key_req, 1);
		compare_value("key_data after first key", key_data, key1);
		send_key_event(key2);
		@(negedge clk_sys);
		compare_value("key_data while second key waits", key_data, key1);
		send_key_event(key3);
		@(negedge clk_sys);
		compare_value("key_data while slot is full", key_data, key1);
		accept_key(key1);
		accept_key(key2);
		extra_req = 0;
		repeat (40) begin
			@(negedge clk_sys);
			if (key_req)
				extra_req++;
		end
		assert (extra_req == 0) else begin
			fail_count++;
			$display("%0t: key_req rose again, the third key was not dropped", $time);
		end

		for (int t = 0; t < 3; t++) begin
			s_l = 16'($urandom);
			s_r = 16'($urandom);
			if (s_r == s_l)
				s_r = s_l ^ 16'h5555;
			@(posedge clk_sys);
			audio_l <= s_l;
			audio_r <= s_r;
			@(posedge clk_sys);
			ones_l = 0;
			ones_r = 0;
			repeat (65536) begin
				@(negedge clk_sys);
				ones_l += int'(AUDIO_L);
				ones_r += int'(AUDIO_R);
			end
			check_density("AUDIO_L", ones_l, int'(s_l));
			check_density("AUDIO_R", ones_r, int'(s_r));
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verification
common/board_cfg_pkg.sv
common/av_pkg.sv
user_io/spi_user_io.sv
video/video_mixer.sv
design/sigma_delta_dac.sv
design/oric_board_top.sv
verification/tb_oric_board.sv
